/* tb.f */
+incdir+.
conv_pkg.sv
conv_pe.sv
slide_window_conv.sv
conv_ctrl.sv
conv_top.sv
tb_conv_top.sv

/* Makefile */
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_conv_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir

HEADERS   := conv_params.svh
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a non-zero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tb_conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module tb_conv_top
    import conv_pkg::*;
();

    localparam int PW      = `CONV_PIX_W;
    localparam int CW      = `CONV_COEF_W;
    localparam int AW      = `CONV_ACC_W;
    localparam int NPIX    = `CONV_IMG_ROWS * `CONV_IMG_COLS;
    localparam int NOUT    = `CONV_OUT_ROWS * `CONV_OUT_COLS;
    localparam int TIMEOUT = 100;                             // cycles per wait

    logic      clk;
    logic      rst;
    logic      req;
    conv_job_t job;
    logic      ack;
    result_t   result;
    int        seed;

    conv_top conv_top_inst
    (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .job    (job),
        .ack    (ack),
        .result (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // correlation, filter not flipped
    function automatic result_t ref_conv(input conv_job_t jb);
        result_t res;
        int      acc;
        pixel_t  p;
        coef_t   k;
        res = '0;
        for (int r = 0; r < `CONV_OUT_ROWS; r++)
        begin
            for (int c = 0; c < `CONV_OUT_COLS; c++)
            begin
                acc = 0;
                for (int i = 0; i < `CONV_FLT_ROWS; i++)
                begin
                    for (int j = 0; j < `CONV_FLT_COLS; j++)
                    begin
                        p = jb.image[((r*`CONV_STRIDE + i)*`CONV_IMG_COLS
                                      + c*`CONV_STRIDE + j)*PW +: PW];
                        k = jb.filter[(i*`CONV_FLT_COLS + j)*CW +: CW];
                        acc = acc + int'(p) * int'(k);
                    end
                end
                res[(r*`CONV_OUT_COLS + c)*AW +: AW] = acc_t'(acc);
            end
        end
        return res;
    endfunction

    function automatic result_t fill_result(input acc_t v);
        result_t res;
        for (int n = 0; n < NOUT; n++)
        begin
            res[n*AW +: AW] = v;
        end
        return res;
    endfunction

    task automatic compare_result(input string name, input result_t exp, input result_t act);
        acc_t e;
        acc_t a;
        for (int n = 0; n < NOUT; n++)
        begin
            e = exp[n*AW +: AW];
            a = act[n*AW +: AW];
            if (e !== a)
            begin
                $display("** Error: %s output %0d expected %0d actual %0d", name, n, e, a);
                $display("Verification failed");
                $fatal(1, "result mismatch");
            end
        end
    endtask

    task automatic compare_ack(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("** Error: %s ack expected %b actual %b", name, exp, act);
            $display("Verification failed");
            $fatal(1, "ack mismatch");
        end
    endtask

    task automatic wait_ack(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (ack !== level)
        begin
            if (cnt >= TIMEOUT)
            begin
                $display("Timed out waiting for ack to go %b during %s", level, what);
                $display("Verification failed");
                $fatal(1, "handshake timeout");
            end
            else
            begin
                tick();
                cnt++;
            end
        end
    endtask

    task automatic make_random_job(output conv_job_t jb);
        for (int n = 0; n < NPIX; n++)
        begin
            jb.image[n*PW +: PW] = pixel_t'($random(seed));
        end
        for (int n = 0; n < `CONV_TAPS; n++)
        begin
            jb.filter[n*CW +: CW] = coef_t'($random(seed));
        end
    endtask

    task automatic start_job(input conv_job_t jb, input string name);
        job = jb;
        req = 1'b1;
        wait_ack(1'b1, name);
    endtask

    task automatic finish_job(input string name);
        req = 1'b0;
        wait_ack(1'b0, name);
    endtask

    task automatic run_job(input string name, input conv_job_t jb, input result_t exp);
        start_job(jb, name);
        compare_result(name, exp, result);
        finish_job(name);
    endtask

    task automatic test_identity();
        conv_job_t jb;
        result_t   exp;
        make_random_job(jb);
        jb.filter = '0;
        jb.filter[4*CW +: CW] = coef_t'(1);                   // centre tap only
        for (int r = 0; r < `CONV_OUT_ROWS; r++)
        begin
            for (int c = 0; c < `CONV_OUT_COLS; c++)
            begin
                exp[(r*`CONV_OUT_COLS + c)*AW +: AW] = acc_t'(pixel_t'(
                    jb.image[((r*`CONV_STRIDE + 1)*`CONV_IMG_COLS
                              + c*`CONV_STRIDE + 1)*PW +: PW]));
            end
        end
        run_job("identity", jb, exp);
    endtask

    task automatic test_box_sum();
        conv_job_t jb;
        for (int n = 0; n < NPIX; n++)
        begin
            jb.image[n*PW +: PW] = pixel_t'(n);               // ramp 0 to 24
        end
        for (int n = 0; n < `CONV_TAPS; n++)
        begin
            jb.filter[n*CW +: CW] = coef_t'(1);
        end
        run_job("box_plus", jb, ref_conv(jb));
        for (int n = 0; n < `CONV_TAPS; n++)
        begin
            jb.filter[n*CW +: CW] = coef_t'(-1);
        end
        run_job("box_minus", jb, ref_conv(jb));
    endtask

    task automatic test_extremes();
        conv_job_t jb;
        for (int n = 0; n < NPIX; n++)
        begin
            jb.image[n*PW +: PW] = pixel_t'(-128);
        end
        for (int n = 0; n < `CONV_TAPS; n++)
        begin
            jb.filter[n*CW +: CW] = coef_t'(-128);
        end
        run_job("extreme_pos", jb, fill_result(acc_t'(147456)));
        for (int n = 0; n < NPIX; n++)
        begin
            jb.image[n*PW +: PW] = pixel_t'(127);
        end
        run_job("extreme_neg", jb, fill_result(acc_t'(-146304)));
    endtask

    task automatic test_random_jobs();
        conv_job_t jb;
        for (int t = 0; t < 20; t++)
        begin
            make_random_job(jb);
            run_job($sformatf("random_%0d", t), jb, ref_conv(jb));
        end
    endtask

    task automatic test_back_pressure();
        conv_job_t jb;
        result_t   exp;
        make_random_job(jb);
        exp = ref_conv(jb);
        start_job(jb, "hold");
        make_random_job(jb);
        job = jb;                                             // inputs free once ack is up
        for (int n = 0; n < 30; n++)
        begin
            compare_ack("hold", 1'b1, ack);
            compare_result("hold", exp, result);
            tick();
        end
        finish_job("hold");
        for (int n = 0; n < 10; n++)
        begin
            tick();
            compare_ack("release", 1'b0, ack);
        end
    endtask

    task automatic test_mid_reset();
        conv_job_t jb;
        make_random_job(jb);
        job = jb;
        req = 1'b1;
        repeat (5) tick();                                    // partway through the taps
        rst = 1'b1;                                           // req stays up through reset
        repeat (16) tick();
        compare_ack("mid_reset", 1'b0, ack);
        compare_result("mid_reset", '0, result);
        rst = 1'b0;
        req = 1'b0;
        tick();
        make_random_job(jb);
        run_job("after_reset", jb, ref_conv(jb));
    endtask

    initial
    begin
        seed = 38;
        rst  = 1'b1;
        req  = 1'b0;
        job  = '0;
        repeat (16) tick();
        rst = 1'b0;
        tick();
        compare_ack("reset", 1'b0, ack);
        compare_result("reset", '0, result);
        test_identity();
        test_box_sum();
        test_extremes();
        test_random_jobs();
        test_back_pressure();
        test_mid_reset();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  conv_job_t job,                                    // stable while req is up
    output logic      ack,
    output result_t   result
);

    conv_step_t step;                                         // sequencer to array
    result_t    sums;                                         // live accumulator values

    // sequencer and host handshake
    conv_ctrl u_ctrl
    (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .ack    (ack),
        .step   (step),
        .sums   (sums),
        .result (result)
    );

    // one element per output window
    slide_window_conv u_array
    (
        .clk    (clk),
        .rst    (rst),
        .step   (step),
        .image  (job.image),
        .filter (job.filter),
        .sums   (sums)
    );

endmodule

`default_nettype wire

/* conv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_ctrl
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    output logic       ack,
    output conv_step_t step,
    input  result_t    sums,
    output result_t    result
);

    localparam tap_idx_t LAST_TAP = tap_idx_t'(`CONV_TAPS - 1);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    tap_idx_t    tap_q;

    // next state
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (req)                                      // four-phase start
                begin
                    state_nxt = LOAD;
                end
            end
            LOAD:
            begin
                state_nxt = MAC;
            end
            MAC:
            begin
                if (tap_q == LAST_TAP)
                begin
                    state_nxt = DONE;
                end
            end
            DONE:
            begin
                state_nxt = WAIT_REL;
            end
            WAIT_REL:
            begin
                if (!req)                                     // host released
                begin
                    state_nxt = IDLE;
                end
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= IDLE;
            tap_q  <= '0;
            ack    <= 1'b0;
            result <= '0;
        end
        else
        begin
            state <= state_nxt;
            case (state)
                LOAD:     tap_q <= '0;
                MAC:      tap_q <= tap_q + 1'b1;              // one tap per cycle
                DONE:
                begin
                    result <= sums;                           // frozen until next job
                    ack    <= 1'b1;
                end
                WAIT_REL:
                begin
                    if (!req)
                    begin
                        ack <= 1'b0;
                    end
                end
                default:  ;
            endcase
        end
    end

    // step broadcast decoded from state
    always_comb
    begin
        step.load = (state == LOAD);
        step.mac  = (state == MAC);
        step.tap  = tap_q;
    end

endmodule

`default_nettype wire

/* slide_window_conv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module slide_window_conv
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  conv_step_t step,
    input  image_t     image,
    input  filter_t    filter,
    output wire result_t sums
);

    localparam int PW = `CONV_PIX_W;
    localparam int AW = `CONV_ACC_W;

    genvar r, c, i, j;

    generate
        for (r = 0; r < `CONV_OUT_ROWS; r = r + 1)
        begin : g_out_row
            for (c = 0; c < `CONV_OUT_COLS; c = c + 1)
            begin : g_out_col
                wire window_t win;                            // this output's 3x3 patch
                wire acc_t    pe_sum;

                // image row r*stride+i, column c*stride+j lands at window i, j
                for (i = 0; i < `CONV_FLT_ROWS; i = i + 1)
                begin : g_win_row
                    for (j = 0; j < `CONV_FLT_COLS; j = j + 1)
                    begin : g_win_col
                        assign win[(i*`CONV_FLT_COLS + j)*PW +: PW] =
                            image[((r*`CONV_STRIDE + i)*`CONV_IMG_COLS
                                   + c*`CONV_STRIDE + j)*PW +: PW];
                    end
                end

                conv_pe u_pe
                (
                    .clk    (clk),
                    .rst    (rst),
                    .step   (step),
                    .window (win),
                    .filter (filter),
                    .sum    (pe_sum)
                );

                // row-major, output 0 at the low end
                assign sums[(r*`CONV_OUT_COLS + c)*AW +: AW] = pe_sum;
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* conv_pe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_pe
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  conv_step_t step,
    input  window_t    window,
    input  filter_t    filter,
    output acc_t       sum
);

    localparam int PROD_W = `CONV_PIX_W + `CONV_COEF_W;

    window_t win_q;                                           // latched window pixels
    filter_t flt_q;                                           // latched coefficients
    acc_t    acc_q;

    pixel_t                    pix;
    coef_t                     coef;
    logic signed [PROD_W-1:0]  prod;
    acc_t                      prod_ext;

    // tap select and multiply
    always_comb
    begin
        pix      = win_q[step.tap*`CONV_PIX_W +: `CONV_PIX_W];
        coef     = flt_q[step.tap*`CONV_COEF_W +: `CONV_COEF_W];
        prod     = pix * coef;                                // signed 8x8
        prod_ext = acc_t'(prod);                              // sign extend to sum width
    end

    // operand registers, loaded once per job
    always_ff @(posedge clk)
    begin
        if (step.load)
        begin
            win_q <= window;
            flt_q <= filter;
        end
    end

    // accumulator
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            acc_q <= '0;
        end
        else if (step.load)
        begin
            acc_q <= '0;                                      // fresh job
        end
        else if (step.mac)
        begin
            acc_q <= acc_q + prod_ext;
        end
    end

    // the sum is final one cycle after the tap 8 mac step,
    // and it stays put until the next load
    assign sum = acc_q;

endmodule

`default_nettype wire

/* conv_pkg.sv */
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

    typedef logic signed [`CONV_PIX_W-1:0]  pixel_t;
    typedef logic signed [`CONV_COEF_W-1:0] coef_t;
    typedef logic signed [`CONV_ACC_W-1:0]  acc_t;
    typedef logic [3:0]                     tap_idx_t;         // counts 0 to 8

    // flat buses, element 0 at the low end, row-major
    typedef logic [`CONV_IMG_ROWS*`CONV_IMG_COLS*`CONV_PIX_W-1:0] image_t;
    typedef logic [`CONV_TAPS*`CONV_COEF_W-1:0]                   filter_t;
    typedef logic [`CONV_TAPS*`CONV_PIX_W-1:0]                    window_t;
    typedef logic [`CONV_OUT_ROWS*`CONV_OUT_COLS*`CONV_ACC_W-1:0] result_t;

    // one job as presented by the host
    typedef struct packed {
        image_t  image;
        filter_t filter;
    } conv_job_t;

    // broadcast from the sequencer to every element
    typedef struct packed {
        logic     load;                                       // latch window and filter
        logic     mac;                                        // accumulate current tap
        tap_idx_t tap;
    } conv_step_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        MAC,
        DONE,
        WAIT_REL
    } ctrl_state_t;

endpackage

`default_nettype wire

/* conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// image and filter geometry
`define CONV_IMG_ROWS 5
`define CONV_IMG_COLS 5
`define CONV_FLT_ROWS 3
`define CONV_FLT_COLS 3
`define CONV_STRIDE   1                                       // 1 or 2 keeps output integral

// valid-mode output grid, no padding
`define CONV_OUT_ROWS (((`CONV_IMG_ROWS - `CONV_FLT_ROWS) / `CONV_STRIDE) + 1)
`define CONV_OUT_COLS (((`CONV_IMG_COLS - `CONV_FLT_COLS) / `CONV_STRIDE) + 1)
`define CONV_TAPS     (`CONV_FLT_ROWS * `CONV_FLT_COLS)

// data widths
`define CONV_PIX_W  8
`define CONV_COEF_W 8
`define CONV_ACC_W  (`CONV_PIX_W + `CONV_COEF_W + 4)          // four guard bits for nine taps

`endif
